/* bench/quad_bram_ctrl_sva.sv */
`timescale 1ns/100ps

module quad_bram_ctrl_sva #(
    parameter int NUM_CE = 8
) (
    input logic              clk,
    input logic              rst,
    input logic              job_fetch_request,
    input logic              job_fetch_ack,
    input logic              job_fetch_in_progress,
    input logic              seq_rd_en,
    input logic [NUM_CE-1:0] ce_execute,
    input logic [NUM_CE-1:0] next_kernel
);
    import qbc_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Fetch handshake
    //////////////////////////////////////////////////////////////////////

    a_req_no_overlap: assert property (@(posedge clk) disable iff (rst)
        $rose(job_fetch_request) |-> !job_fetch_in_progress)
        else $error("fetch request rose during a fetch");

    // Drops one cycle after the ack
    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request && job_fetch_ack |=> !job_fetch_request)
        else $error("fetch request held after its ack");

    //////////////////////////////////////////////////////////////////////
    // CE issue timing
    //////////////////////////////////////////////////////////////////////

    a_exec_stage0: assert property (@(posedge clk) disable iff (rst)
        ce_execute[0] == $past(seq_rd_en, SEQ_RD_LATENCY))
        else $error("execute at stage 0 not aligned to the read strobe");

    // Final strobe is the last one of a consecutive run
    a_next_stage0: assert property (@(posedge clk) disable iff (rst)
        next_kernel[0] == ($past(seq_rd_en) && !seq_rd_en))
        else $error("next kernel at stage 0 not one cycle after pass end");

    for (genvar k = 1; k < NUM_CE; k++) begin : g_stage
        a_exec_shift: assert property (@(posedge clk) disable iff (rst)
            ce_execute[k] == $past(ce_execute[k-1]))
            else $error("execute chain broken at stage %0d", k);
        a_next_shift: assert property (@(posedge clk) disable iff (rst)
            next_kernel[k] == $past(next_kernel[k-1]))
            else $error("next kernel chain broken at stage %0d", k);
    end

endmodule

bind quad_bram_ctrl quad_bram_ctrl_sva #(.NUM_CE(NUM_CE)) u_sva (.*);

/* bench/tb_quad_bram_ctrl.sv */
`timescale 1ns/100ps

module tb_quad_bram_ctrl;
    import qbc_pkg::*;

    localparam int NUM_CE   = 8;
    localparam int NUM_JOBS = 20;

    logic                clk;
    logic                rst;
    dim_t                num_input_cols;
    dim_t                num_input_rows;
    seq_addr_t           pix_seq_data_full_count;
    logic                job_start;
    logic                job_fetch_ack;
    logic                job_fetch_complete;
    logic                job_complete_ack;
    pfb_cnt_t            pfb_full_count;
    logic                last_kernel;
    logic                pipeline_flushed;
    logic                job_accept;
    logic                job_fetch_request;
    logic                job_fetch_in_progress;
    logic                job_complete;
    job_state_t          state;
    dim_t                input_row;
    dim_t                input_col;
    logic                pfb_rden;
    logic                seq_rd_en;
    seq_addr_t           seq_rd_addr;
    logic [NUM_CE-1:0]   ce_execute;
    logic [NUM_CE-1:0]   next_kernel;

    // Job settings, drawn up front so the timeout can be sized
    int job_cols [NUM_JOBS];
    int job_rows [NUM_JOBS];
    int job_len  [NUM_JOBS];
    int cycle_limit;
    int cycles;
    int completions;

    // Reference model state
    int          job_reads;
    int          seq_idx;
    int          low_ends;
    int          out_row;
    longint      rd_total;
    longint      loaded_total;
    logic        end_seen;
    logic        after_final;
    logic        start_prev;
    logic        cpl_prev;
    logic        ack_prev;
    logic        cpl_this_job;
    logic        exp_idle;
    logic        fetch_busy;

    quad_bram_ctrl #(
        .NUM_CE (NUM_CE)
    ) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int gap;

        rst                     = 1'b1;
        num_input_cols          = '0;
        num_input_rows          = '0;
        pix_seq_data_full_count = seq_addr_t'(1);
        job_start               = 1'b0;
        job_complete_ack        = 1'b0;
        completions             = 0;
        void'($urandom(32'hde8a535f));

        // Budget: repeated passes, fetch round trips, handshakes
        cycle_limit = 200;
        for (int j = 0; j < NUM_JOBS; j++) begin
            job_cols[j] = int'($urandom % 16);
            job_rows[j] = 3 + int'($urandom % 5);
            job_len[j]  = 1 + int'($urandom % 150);
            cycle_limit += (job_rows[j] + 1) * ((job_cols[j] + 1) * 6 + 4) * 8;
            cycle_limit += ((job_rows[j] + 1) * (job_cols[j] + 1) / 4 + 2) * 24 + 100;
        end

        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (int j = 0; j < NUM_JOBS; j++) begin
            @(negedge clk);
            num_input_cols          = dim_t'(job_cols[j]);
            num_input_rows          = dim_t'(job_rows[j]);
            pix_seq_data_full_count = seq_addr_t'(job_len[j]);
            job_start               = 1'b1;
            @(negedge clk);
            job_start = 1'b0;
            while (!job_complete) begin
                @(negedge clk);
            end
            gap = int'($urandom % 6);
            repeat (gap) @(negedge clk);
            job_complete_ack = 1'b1;
            @(negedge clk);
            job_complete_ack = 1'b0;
            repeat (2) @(negedge clk);
        end

        if (completions == NUM_JOBS) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "wrong number of completed jobs");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Loader, flush and kernel responders
    //////////////////////////////////////////////////////////////////////

    // Loader side of the fetch handshake
    initial begin
        int wait_cycles;

        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        pfb_full_count     = '0;
        forever begin
            @(negedge clk);
            if (job_fetch_request) begin
                wait_cycles = int'($urandom % 6);
                repeat (wait_cycles) @(negedge clk);
                job_fetch_ack = 1'b1;
                @(negedge clk);
                job_fetch_ack = 1'b0;
                wait_cycles = 1 + int'($urandom % 6);
                repeat (wait_cycles) @(negedge clk);
                pfb_full_count     = pfb_cnt_t'(4 + $urandom % 37);
                job_fetch_complete = 1'b1;
                @(negedge clk);
                job_fetch_complete = 1'b0;
            end
        end
    end

    initial begin
        int wait_cycles;

        pipeline_flushed = 1'b0;
        forever begin
            @(negedge clk);
            if (state == WAIT_JOB_DONE && !pipeline_flushed) begin
                wait_cycles = int'($urandom % 8);
                repeat (wait_cycles) @(negedge clk);
                pipeline_flushed = 1'b1;
                @(negedge clk);
                pipeline_flushed = 1'b0;
            end
        end
    end

    // Mostly high so rows advance
    initial begin
        last_kernel = 1'b0;
        forever begin
            @(negedge clk);
            last_kernel = ($urandom % 5) < 3;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycles = 0;
        end else begin
            cycles++;
            if (cycles > cycle_limit) begin
                report_failure("Timeout: jobs did not finish within the cycle budget");
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        int c;
        int r;

        c = int'(num_input_cols);
        r = int'(num_input_rows);
        if (rst) begin
            job_reads    = 0;
            seq_idx      = 0;
            low_ends     = 0;
            out_row      = 0;
            rd_total     = 0;
            loaded_total = 0;
            end_seen     = 1'b0;
            after_final  = 1'b0;
            start_prev   = 1'b0;
            cpl_prev     = 1'b0;
            ack_prev     = 1'b0;
            cpl_this_job = 1'b0;
            exp_idle     = 1'b1;
            fetch_busy   = 1'b0;
        end else begin
            // FSM state where the model pins it down
            if (exp_idle) begin
                assert (state == IDLE)
                    else report_mismatch("state", 32'(state), 32'(IDLE));
            end else if (job_complete) begin
                assert (state == SEND_COMPLETE)
                    else report_mismatch("state", 32'(state), 32'(SEND_COMPLETE));
            end else if (end_seen) begin
                assert (state == WAIT_JOB_DONE)
                    else report_mismatch("state", 32'(state), 32'(WAIT_JOB_DONE));
            end

            // Accept one cycle after a start seen in IDLE
            assert (job_accept == start_prev)
                else report_mismatch("job_accept", 32'(job_accept), 32'(start_prev));
            start_prev = job_start && exp_idle;
            if (start_prev) begin
                exp_idle = 1'b0;
            end

            // Completion holds until the cycle after its ack
            if (ack_prev) begin
                assert (!job_complete)
                    else report_mismatch("job_complete", 32'(job_complete), 32'h0);
            end else if (cpl_prev) begin
                assert (job_complete)
                    else report_mismatch("job_complete", 32'(job_complete), 32'h1);
            end
            if (job_complete && !cpl_prev) begin
                assert (end_seen && !cpl_this_job)
                    else report_failure("job_complete rose without a finished job");
                cpl_this_job = 1'b1;
                completions++;
            end

            // Fetch in flight from the cycle after the ack to the cycle after complete
            assert (job_fetch_in_progress == fetch_busy)
                else report_mismatch("job_fetch_in_progress",
                                     32'(job_fetch_in_progress), 32'(fetch_busy));
            if (job_fetch_complete) begin
                fetch_busy = 1'b0;
            end else if (job_fetch_ack) begin
                fetch_busy = 1'b1;
            end

            // Prefetch reads
            if (pfb_rden) begin
                rd_total++;
                assert (rd_total <= loaded_total)
                    else report_failure("pfb read with no loaded entries left");
                assert (int'(input_row) == job_reads / (c + 1))
                    else report_mismatch("input_row", 32'(input_row), job_reads / (c + 1));
                assert (int'(input_col) == job_reads % (c + 1))
                    else report_mismatch("input_col", 32'(input_col), job_reads % (c + 1));
                job_reads++;
            end
            if (job_fetch_complete) begin
                loaded_total += longint'(pfb_full_count);
            end

            // Pixel-sequence passes
            if (after_final) begin
                assert (!seq_rd_en)
                    else report_failure("seq_rd_en stayed high after the final strobe");
            end
            after_final = 1'b0;
            // Strobes of one pass come on consecutive cycles
            assert (seq_rd_en || seq_idx == 0)
                else report_failure("seq_rd_en dropped in the middle of a pass");
            if (seq_rd_en) begin
                assert (!end_seen)
                    else report_failure("seq_rd_en strobe after the last pass of the job");
                assert (int'(seq_rd_addr) == seq_idx % int'(pix_seq_data_full_count))
                    else report_mismatch("seq_rd_addr", 32'(seq_rd_addr),
                                         seq_idx % int'(pix_seq_data_full_count));
                if (seq_idx == (c + 1) * (int'(CYCLE_COUNT) + 1) - 1) begin
                    seq_idx     = 0;
                    after_final = 1'b1;
                    if (!last_kernel) begin
                        low_ends++;
                    end else if (out_row == r) begin
                        end_seen = 1'b1;
                    end else begin
                        out_row++;
                    end
                end else begin
                    seq_idx++;
                end
            end

            // Per-job totals at the ack
            if (job_complete_ack && job_complete) begin
                assert (job_reads == (r + 1) * (c + 1))
                    else report_mismatch("pfb_rden count", job_reads, (r + 1) * (c + 1));
                job_reads    = 0;
                low_ends     = 0;
                out_row      = 0;
                end_seen     = 1'b0;
                cpl_this_job = 1'b0;
                exp_idle     = 1'b1;
            end
            cpl_prev = job_complete;
            ack_prev = job_complete_ack && job_complete;
        end
    end

endmodule

/* flist.f */
hw/qbc_pkg.sv
hw/job_sequencer.sv
hw/pfb_reader.sv
hw/pix_seq_reader.sv
hw/ce_issue_chain.sv
hw/quad_bram_ctrl.sv
bench/quad_bram_ctrl_sva.sv
bench/tb_quad_bram_ctrl.sv

/* hw/ce_issue_chain.sv */
`timescale 1ns/100ps

module ce_issue_chain #(
    parameter int NUM_CE = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              seq_rd_en,
    input  logic              pass_done,
    output logic [NUM_CE-1:0] ce_execute,
    output logic [NUM_CE-1:0] next_kernel
);
    import qbc_pkg::*;

    // Covers the sequence BRAM read latency minus the stage 0 register
    logic [SEQ_RD_LATENCY-2:0] rd_dly;

    //////////////////////////////////////////////////////////////////////
    // Read latency and CE shift chains
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_dly      <= '0;
            ce_execute  <= '0;
            next_kernel <= '0;
        end else begin
            rd_dly <= {rd_dly[SEQ_RD_LATENCY-3:0], seq_rd_en};

            // Stage 0 sees the strobe SEQ_RD_LATENCY cycles late
            ce_execute[0]  <= rd_dly[SEQ_RD_LATENCY-2];
            // Kernel switch one cycle after the final strobe
            next_kernel[0] <= pass_done;

            // One stage per cycle down the CEs
            for (int k = 1; k < NUM_CE; k++) begin
                ce_execute[k]  <= ce_execute[k-1];
                next_kernel[k] <= next_kernel[k-1];
            end
        end
    end

endmodule

/* hw/job_sequencer.sv */
`timescale 1ns/100ps

module job_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                job_start,
    input  logic                job_fetch_ack,
    input  logic                job_fetch_complete,
    input  logic                job_complete_ack,
    input  logic                last_kernel,
    input  logic                pipeline_flushed,
    input  logic                prime_done,
    input  logic                pass_done,
    input  logic                pfb_empty_need,
    input  qbc_pkg::dim_t       num_input_rows,
    output logic                job_accept,
    output logic                job_fetch_request,
    output logic                job_fetch_in_progress,
    output logic                job_complete,
    output qbc_pkg::job_state_t state,
    output logic                prime_en,
    output logic                row_pass_start,
    output logic                row_refill
);
    import qbc_pkg::*;

    // State to resume once the loader has refilled the pfb
    job_state_t return_state;
    // Output row of the pass in flight
    dim_t       output_row;
    // Next pass held back until the refill row is read
    logic       refill_wait;
    logic       last_row;

    assign last_row = (output_row == num_input_rows);

    //////////////////////////////////////////////////////////////////////
    // Fetch in progress
    //////////////////////////////////////////////////////////////////////

    // High from the cycle after the ack to the cycle after complete
    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_complete) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_request && job_fetch_ack) begin
            job_fetch_in_progress <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Job FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= IDLE;
            return_state      <= IDLE;
            output_row        <= '0;
            refill_wait       <= 1'b0;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            prime_en          <= 1'b0;
            row_pass_start    <= 1'b0;
            row_refill        <= 1'b0;
        end else begin
            // Single-cycle strobes
            job_accept     <= 1'b0;
            prime_en       <= 1'b0;
            row_pass_start <= 1'b0;
            row_refill     <= 1'b0;

            // Request falls the cycle after the ack
            if (job_fetch_ack) begin
                job_fetch_request <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        prime_en   <= 1'b1;
                        state      <= PRIME_BUFFER;
                    end
                end
                PRIME_BUFFER: begin
                    // Buffer ran dry before the first rows were in
                    if (pfb_empty_need) begin
                        return_state      <= PRIME_BUFFER;
                        job_fetch_request <= 1'b1;
                        state             <= WAIT_PFB_LOAD;
                    end else if (prime_done) begin
                        row_pass_start <= 1'b1;
                        state          <= CE_ACTIVE;
                    end
                end
                WAIT_PFB_LOAD: begin
                    if (job_fetch_complete && job_fetch_in_progress) begin
                        state <= return_state;
                    end
                end
                CE_ACTIVE: begin
                    if (pass_done) begin
                        // last_kernel sampled on the final strobe
                        if (last_kernel && last_row) begin
                            state <= WAIT_JOB_DONE;
                        end else if (last_kernel) begin
                            output_row  <= output_row + dim_t'(1);
                            row_refill  <= 1'b1;
                            refill_wait <= 1'b1;
                        end else begin
                            // Same row again with the next kernel set
                            row_pass_start <= 1'b1;
                        end
                    end else if (refill_wait && pfb_empty_need) begin
                        return_state      <= CE_ACTIVE;
                        job_fetch_request <= 1'b1;
                        state             <= WAIT_PFB_LOAD;
                    end else if (refill_wait && prime_done) begin
                        refill_wait    <= 1'b0;
                        row_pass_start <= 1'b1;
                    end
                end
                WAIT_JOB_DONE: begin
                    // Let the CE pipeline drain first
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= SEND_COMPLETE;
                    end
                end
                SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        output_row   <= '0;
                        refill_wait  <= 1'b0;
                        state        <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/pfb_reader.sv */
`timescale 1ns/100ps

module pfb_reader (
    input  logic              clk,
    input  logic              rst,
    input  logic              prime_en,
    input  logic              row_refill,
    input  logic              job_fetch_complete,
    input  qbc_pkg::pfb_cnt_t pfb_full_count,
    input  qbc_pkg::dim_t     num_input_cols,
    input  qbc_pkg::dim_t     num_input_rows,
    input  logic              job_complete_ack,
    output logic              pfb_rden,
    output qbc_pkg::dim_t     input_row,
    output qbc_pkg::dim_t     input_col,
    output logic              prime_done,
    output logic              pfb_empty_need
);
    import qbc_pkg::*;

    // Entries still in the prefetch buffer
    pfb_cnt_t pfb_count;
    // Whole input rows still to be read
    dim_t     rows_owed;
    logic     row_end;
    logic     rows_left;

    // One entry per cycle while anything is owed and loaded
    assign pfb_rden       = (rows_owed != '0) && (pfb_count != '0);
    assign pfb_empty_need = (rows_owed != '0) && (pfb_count == '0);
    assign row_end        = pfb_rden && (input_col == num_input_cols);
    // Input rows not yet read
    assign rows_left      = (input_row <= num_input_rows);

    always_ff @(posedge clk) begin
        if (rst || job_complete_ack) begin
            pfb_count  <= '0;
            rows_owed  <= '0;
            input_row  <= '0;
            input_col  <= '0;
            prime_done <= 1'b0;
        end else begin
            // Loader reports a fresh fill
            if (job_fetch_complete) begin
                pfb_count <= pfb_full_count;
            end else if (pfb_rden) begin
                pfb_count <= pfb_count - pfb_cnt_t'(1);
            end

            if (prime_en) begin
                rows_owed <= dim_t'(PRIME_ROWS);
            end else if (row_refill) begin
                rows_owed <= rows_left ? dim_t'(1) : '0;
            end else if (row_end) begin
                rows_owed <= rows_owed - dim_t'(1);
            end

            // Walk input rows and columns
            if (row_end) begin
                input_col <= '0;
                input_row <= input_row + dim_t'(1);
            end else if (pfb_rden) begin
                input_col <= input_col + dim_t'(1);
            end

            // Last owed row read, or a refill with nothing left to read
            prime_done <= (row_end && rows_owed == dim_t'(1)) || (row_refill && !rows_left);
        end
    end

endmodule

/* hw/pix_seq_reader.sv */
`timescale 1ns/100ps

module pix_seq_reader (
    input  logic               clk,
    input  logic               rst,
    input  logic               row_pass_start,
    input  qbc_pkg::dim_t      num_input_cols,
    input  qbc_pkg::seq_addr_t pix_seq_data_full_count,
    output logic               seq_rd_en,
    output qbc_pkg::seq_addr_t seq_rd_addr,
    output logic               pass_done
);
    import qbc_pkg::*;

    // Read within the current output column
    cyc_t cyc_counter;
    // Output column of the current read
    dim_t output_col;
    logic last_cyc;
    logic addr_wrap;

    assign last_cyc  = (cyc_counter == CYCLE_COUNT);
    // Address runs modulo the sequence length
    assign addr_wrap = (seq_rd_addr == pix_seq_data_full_count - seq_addr_t'(1));
    // High during the final strobe of the pass
    assign pass_done = seq_rd_en && last_cyc && (output_col == num_input_cols);

    //////////////////////////////////////////////////////////////////////
    // Pass burst
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rd_en   <= 1'b0;
            cyc_counter <= '0;
            output_col  <= '0;
            seq_rd_addr <= '0;
        end else if (row_pass_start) begin
            // Counters already cleared by the previous pass end
            seq_rd_en <= 1'b1;
        end else if (pass_done) begin
            seq_rd_en   <= 1'b0;
            cyc_counter <= '0;
            output_col  <= '0;
            seq_rd_addr <= '0;
        end else if (seq_rd_en) begin
            if (last_cyc) begin
                cyc_counter <= '0;
                output_col  <= output_col + dim_t'(1);
            end else begin
                cyc_counter <= cyc_counter + cyc_t'(1);
            end

            if (addr_wrap) begin
                seq_rd_addr <= '0;
            end else begin
                seq_rd_addr <= seq_rd_addr + seq_addr_t'(1);
            end
        end
    end

endmodule

/* hw/qbc_pkg.sv */
package qbc_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // log2 of the 1024-deep BRAM
    localparam int DIM_W      = 10;
    localparam int PFB_CNT_W  = 10;
    // Sequence BRAM holds (depth / 2) * 5 words
    localparam int SEQ_ADDR_W = 12;
    localparam int CYC_W      = 3;

    // Input or output row/column index
    typedef logic [DIM_W-1:0]      dim_t;
    // Entries left in the prefetch buffer
    typedef logic [PFB_CNT_W-1:0]  pfb_cnt_t;
    // Pixel-sequence address or length
    typedef logic [SEQ_ADDR_W-1:0] seq_addr_t;
    // Read index within one output column
    typedef logic [CYC_W-1:0]      cyc_t;

    // Job FSM
    typedef enum logic [2:0] {
        IDLE,
        PRIME_BUFFER,
        WAIT_PFB_LOAD,
        CE_ACTIVE,
        WAIT_JOB_DONE,
        SEND_COMPLETE
    } job_state_t;

    //////////////////////////////////////////////////////////////////////
    // Fixed constants
    //////////////////////////////////////////////////////////////////////

    // Reads per output column, minus one
    localparam cyc_t CYCLE_COUNT    = 3'd5;
    // Input rows buffered before the first pass
    localparam int   PRIME_ROWS     = 3;
    // Read strobe to execute at CE stage 0
    localparam int   SEQ_RD_LATENCY = 3;

endpackage

/* hw/quad_bram_ctrl.sv */
`timescale 1ns/100ps

module quad_bram_ctrl #(
    parameter int NUM_CE = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  qbc_pkg::dim_t       num_input_cols,
    input  qbc_pkg::dim_t       num_input_rows,
    input  qbc_pkg::seq_addr_t  pix_seq_data_full_count,
    input  logic                job_start,
    input  logic                job_fetch_ack,
    input  logic                job_fetch_complete,
    input  logic                job_complete_ack,
    input  qbc_pkg::pfb_cnt_t   pfb_full_count,
    input  logic                last_kernel,
    input  logic                pipeline_flushed,
    output logic                job_accept,
    output logic                job_fetch_request,
    output logic                job_fetch_in_progress,
    output logic                job_complete,
    output qbc_pkg::job_state_t state,
    output qbc_pkg::dim_t       input_row,
    output qbc_pkg::dim_t       input_col,
    output logic                pfb_rden,
    output logic                seq_rd_en,
    output qbc_pkg::seq_addr_t  seq_rd_addr,
    output logic [NUM_CE-1:0]   ce_execute,
    output logic [NUM_CE-1:0]   next_kernel
);

    // Sequencer to readers
    logic prime_en;
    logic row_pass_start;
    logic row_refill;
    // Readers back to sequencer
    logic prime_done;
    logic pass_done;
    logic pfb_empty_need;

    //////////////////////////////////////////////////////////////////////
    // Job control
    //////////////////////////////////////////////////////////////////////

    job_sequencer u_job_sequencer (
        .clk                   (clk),
        .rst                   (rst),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .last_kernel           (last_kernel),
        .pipeline_flushed      (pipeline_flushed),
        .prime_done            (prime_done),
        .pass_done             (pass_done),
        .pfb_empty_need        (pfb_empty_need),
        .num_input_rows        (num_input_rows),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .state                 (state),
        .prime_en              (prime_en),
        .row_pass_start        (row_pass_start),
        .row_refill            (row_refill)
    );

    //////////////////////////////////////////////////////////////////////
    // Readers and CE issue
    //////////////////////////////////////////////////////////////////////

    pfb_reader u_pfb_reader (
        .clk                (clk),
        .rst                (rst),
        .prime_en           (prime_en),
        .row_refill         (row_refill),
        .job_fetch_complete (job_fetch_complete),
        .pfb_full_count     (pfb_full_count),
        .num_input_cols     (num_input_cols),
        .num_input_rows     (num_input_rows),
        .job_complete_ack   (job_complete_ack),
        .pfb_rden           (pfb_rden),
        .input_row          (input_row),
        .input_col          (input_col),
        .prime_done         (prime_done),
        .pfb_empty_need     (pfb_empty_need)
    );

    pix_seq_reader u_pix_seq_reader (
        .clk                     (clk),
        .rst                     (rst),
        .row_pass_start          (row_pass_start),
        .num_input_cols          (num_input_cols),
        .pix_seq_data_full_count (pix_seq_data_full_count),
        .seq_rd_en               (seq_rd_en),
        .seq_rd_addr             (seq_rd_addr),
        .pass_done               (pass_done)
    );

    ce_issue_chain #(
        .NUM_CE (NUM_CE)
    ) u_ce_issue_chain (
        .clk         (clk),
        .rst         (rst),
        .seq_rd_en   (seq_rd_en),
        .pass_done   (pass_done),
        .ce_execute  (ce_execute),
        .next_kernel (next_kernel)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile and run the quad BRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tb_quad_bram_ctrl -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
